/* wr_tests.txt */
// One burst per line, all fields hex
// id addr len size burst resp last_addr
1 00001002 00 2 1 0 00001002
2 00002006 07 2 1 0 00002020
3 00003010 03 2 0 0 00003010
4 00004ff0 07 2 1 0 00004ffc
5 00005000 03 3 1 2 00005018
6 00006003 05 0 1 0 00006008
7 00007001 02 1 2 0 00007004
8 00009ffc 01 2 3 0 00009ffc
9 00008000 ff 2 1 0 000083fc
a 0000a100 0f 2 1 0 0000a13c
b 0000b0f8 03 2 0 0 0000b0f8
c 0000cffe 02 1 1 0 0000cffe
d 0000d000 01 4 1 2 0000d010
e 0000e7fe 00 1 1 0 0000e7fe
f 0000fff0 03 2 2 0 0000fffc
0 00010000 04 2 1 0 00010010

/* sim.f */
axi_wr_pkg.sv
sync_fifo.sv
aw_decode.sv
burst_engine.sv
wresp_gen.sv
axi_wr_slave.sv
tb_axi_wr_slave.sv

/* Bender.yml */
package:
  name: axi_wr_slave

sources:
  - axi_wr_pkg.sv
  - sync_fifo.sv
  - aw_decode.sv
  - burst_engine.sv
  - wresp_gen.sv
  - axi_wr_slave.sv
  - target: simulation
    files:
      - tb_axi_wr_slave.sv

/* tb_axi_wr_slave.sv */
/*
 * Testbench for the AXI4 write slave: clock and reset, AW and W drivers,
 * memory port and B channel monitors, typed compare tasks.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_wr_slave;

    localparam int TIMEOUT   = 2000;
    localparam int FIELDS    = 7;
    localparam int MAX_TESTS = 32;

    logic                  clk;
    logic                  rst_n;
    axi_wr_pkg::aw_cmd_t   aw;
    logic                  aw_valid;
    logic                  aw_ready;
    axi_wr_pkg::w_beat_t   w;
    logic                  w_valid;
    logic                  w_ready;
    axi_wr_pkg::b_resp_t   b;
    logic                  b_valid;
    logic                  b_ready;
    axi_wr_pkg::mem_wr_t   mem;
    logic                  mem_we;
    logic                  mem_ready;

    // Test table from the data file with seven words per burst
    logic [31:0]                     vec [FIELDS*MAX_TESTS];
    axi_wr_pkg::aw_cmd_t             cmds [MAX_TESTS];
    axi_wr_pkg::b_resp_t             exp_b [MAX_TESTS];
    logic [axi_wr_pkg::ADDR_W-1:0]   exp_last [MAX_TESTS];
    bit                              test_fail [MAX_TESTS];
    int                              num_tests;
    int                              err_count;
    int                              resp_count;
    int                              pass_count;
    bit                              timeout_hit;
    // W beats in the order they were offered to the DUT
    axi_wr_pkg::w_beat_t             w_exp [$];
    int                              mon_test;
    int                              mon_beat;
    logic [axi_wr_pkg::ADDR_W-1:0]   prev_addr;
    int                              stall_left;

    axi_wr_slave u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .aw        (aw),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .w         (w),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .b         (b),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .mem       (mem),
        .mem_we    (mem_we),
        .mem_ready (mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------
    // Reference model and compare tasks
    // ----------------------------------------
    // Address of beat k from the start address and the previous beat
    function automatic logic [axi_wr_pkg::ADDR_W-1:0] beat_addr(
        input axi_wr_pkg::aw_cmd_t c, input int k,
        input logic [axi_wr_pkg::ADDR_W-1:0] prev);
        logic [axi_wr_pkg::ADDR_W-1:0] step;
        logic [axi_wr_pkg::ADDR_W-1:0] base;
        logic [axi_wr_pkg::ADDR_W-1:0] nxt;
        if (k == 0) return c.addr;
        step = (c.burst == axi_wr_pkg::FIXED) ? '0 : (32'd1 << c.size);
        // Beat 1 steps from the aligned start
        base = (k == 1) ? (c.addr & ~((32'd1 << c.size) - 32'd1)) : prev;
        nxt  = base + step;
        // Leaving the 4 KB page repeats the previous address
        if (nxt[axi_wr_pkg::ADDR_W-1:axi_wr_pkg::PAGE_BIT] !=
            c.addr[axi_wr_pkg::ADDR_W-1:axi_wr_pkg::PAGE_BIT]) return prev;
        return nxt;
    endfunction

    task automatic check_mem(input axi_wr_pkg::mem_wr_t got,
                             input axi_wr_pkg::mem_wr_t want, input int t);
        if (got !== want) begin
            $display("CHECK FAILED mem (test %0d beat %0d): got id %h addr %h data %h",
                     t, mon_beat, got.id, got.addr, got.data,
                     " strb %h last %h, expected id %h addr %h data %h strb %h last %h",
                     got.strb, got.last, want.id, want.addr, want.data,
                     want.strb, want.last);
            err_count++;
            test_fail[t] = 1'b1;
        end
    endtask

    task automatic check_resp(input axi_wr_pkg::b_resp_t got,
                              input axi_wr_pkg::b_resp_t want, input int t);
        if (got !== want) begin
            $display("CHECK FAILED b (test %0d): got id %h resp %h, expected id %h resp %h",
                     t, got.id, got.resp, want.id, want.resp);
            err_count++;
            test_fail[t] = 1'b1;
        end
    endtask

    // Data file columns are id addr len size burst resp last_addr
    task automatic load_tests();
        int base;
        num_tests = 0;
        while (num_tests < MAX_TESTS && !$isunknown(vec[num_tests*FIELDS])) begin
            base = num_tests * FIELDS;
            cmds[num_tests].id     = vec[base][axi_wr_pkg::ID_W-1:0];
            cmds[num_tests].addr   = vec[base+1];
            cmds[num_tests].len    = vec[base+2][axi_wr_pkg::LEN_W-1:0];
            cmds[num_tests].size   = vec[base+3][axi_wr_pkg::SIZE_W-1:0];
            cmds[num_tests].burst  = axi_wr_pkg::burst_e'(vec[base+4][1:0]);
            exp_b[num_tests].id    = vec[base][axi_wr_pkg::ID_W-1:0];
            exp_b[num_tests].resp  = axi_wr_pkg::resp_e'(vec[base+5][1:0]);
            exp_last[num_tests]    = vec[base+6];
            test_fail[num_tests]   = 1'b0;
            num_tests++;
        end
    endtask

    // ----------------------------------------
    // AXI master drivers
    // ----------------------------------------
    task automatic drive_aw();
        int n;
        for (int t = 0; t < num_tests && !timeout_hit; t++) begin
            aw       <= cmds[t];
            aw_valid <= 1'b1;
            n = 0;
            do begin
                @(posedge clk);
                n++;
            end while (!aw_ready && n < TIMEOUT);
            if (!aw_ready) begin
                $display("Timeout: AW handshake for test %0d never completed", t);
                timeout_hit = 1'b1;
            end
        end
        aw_valid <= 1'b0;
    endtask

    task automatic drive_w();
        axi_wr_pkg::w_beat_t wb;
        int n;
        for (int t = 0; t < num_tests && !timeout_hit; t++) begin
            for (int k = 0; k <= int'(cmds[t].len) && !timeout_hit; k++) begin
                wb.data = $urandom;
                wb.strb = axi_wr_pkg::STRB_W'($urandom);
                wb.last = (k == int'(cmds[t].len));
                w_exp.push_back(wb);
                w       <= wb;
                w_valid <= 1'b1;
                n = 0;
                do begin
                    @(posedge clk);
                    n++;
                end while (!w_ready && n < TIMEOUT);
                if (!w_ready) begin
                    $display("Timeout: W beat %0d of test %0d was never accepted", k, t);
                    timeout_hit = 1'b1;
                end
            end
        end
        w_valid <= 1'b0;
    endtask

    // Random memory stalls and B back-pressure in stretches
    always @(posedge clk) begin
        mem_ready <= ($urandom % 4) != 0;
        if (stall_left > 0) begin
            b_ready <= 1'b0;
            stall_left--;
        end else if (($urandom % 16) == 0) begin
            stall_left = 4 + ($urandom % 20);
            b_ready <= 1'b0;
        end else begin
            b_ready <= 1'b1;
        end
    end

    // ----------------------------------------
    // Monitors
    // ----------------------------------------
    always @(posedge clk) begin : mem_monitor
        axi_wr_pkg::mem_wr_t           want;
        axi_wr_pkg::w_beat_t           wb;
        logic [axi_wr_pkg::ADDR_W-1:0] rule_addr;
        if (rst_n && mem_we) begin
            if (mon_test >= num_tests || w_exp.size() == 0) begin
                $display("Memory port issued a beat with no write outstanding");
                err_count++;
            end else begin
                wb        = w_exp.pop_front();
                rule_addr = beat_addr(cmds[mon_test], mon_beat, prev_addr);
                want.id   = cmds[mon_test].id;
                want.addr = rule_addr;
                want.data = wb.data;
                want.strb = wb.strb;
                want.last = wb.last;
                if (mon_beat == int'(cmds[mon_test].len)) begin
                    if (rule_addr !== exp_last[mon_test]) begin
                        $display("Test %0d: table last address disagrees with the address rule",
                                 mon_test);
                        err_count++;
                        test_fail[mon_test] = 1'b1;
                    end
                    // Final beat is held to the address from the table
                    want.addr = exp_last[mon_test];
                end
                check_mem(mem, want, mon_test);
                prev_addr = rule_addr;
                if (mon_beat == int'(cmds[mon_test].len)) begin
                    mon_test++;
                    mon_beat = 0;
                end else begin
                    mon_beat++;
                end
            end
        end
    end

    always @(posedge clk) begin : b_monitor
        if (rst_n && b_valid && b_ready) begin
            if (resp_count >= num_tests) begin
                $display("B channel returned a response with no burst outstanding");
                err_count++;
            end else begin
                check_resp(b, exp_b[resp_count], resp_count);
                $display("test %0d id %h len %0d size %0d: %s", resp_count,
                         cmds[resp_count].id, cmds[resp_count].len,
                         cmds[resp_count].size, test_fail[resp_count] ? "FAIL" : "ok");
                if (!test_fail[resp_count]) pass_count++;
                resp_count++;
            end
        end
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin : main
        int n;
        void'($urandom(4104));
        rst_n      = 1'b0;
        aw         = '0;
        aw_valid   = 1'b0;
        w          = '0;
        w_valid    = 1'b0;
        b_ready    = 1'b0;
        mem_ready  = 1'b0;
        err_count  = 0;
        resp_count = 0;
        pass_count = 0;
        mon_test   = 0;
        mon_beat   = 0;
        prev_addr  = '0;
        stall_left = 0;
        timeout_hit = 1'b0;
        $readmemh("wr_tests.txt", vec);
        load_tests();
        if (num_tests == 0) begin
            $display("No tests were read from the test table");
            err_count++;
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (!aw_ready || !w_ready || mem_we || b_valid) begin
            $display("CHECK FAILED after reset: aw_ready %h w_ready %h mem_we %h b_valid %h",
                     aw_ready, w_ready, mem_we, b_valid, ", expected 1 1 0 0");
            err_count++;
        end
        fork
            drive_aw();
            drive_w();
        join
        // Drain the remaining beats and responses
        n = 0;
        while (resp_count < num_tests && !timeout_hit && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (resp_count < num_tests && !timeout_hit) begin
            $display("Timeout: only %0d of %0d responses arrived", resp_count, num_tests);
            timeout_hit = 1'b1;
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 num_tests, pass_count, num_tests - pass_count, err_count);
        if (timeout_hit || err_count != 0 || pass_count != num_tests) begin
            $display("Regression failed");
        end else begin
            $display("Regression passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* axi_wr_slave.sv */
/*
 * AXI4 write slave top: AW and W buffers, burst engine and
 * response stage.
 */
`timescale 1ns/1ps
`default_nettype none

module axi_wr_slave (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    // AXI4 write channels
    input  wire axi_wr_pkg::aw_cmd_t   aw,
    input  wire logic                  aw_valid,
    output logic                       aw_ready,
    input  wire axi_wr_pkg::w_beat_t   w,
    input  wire logic                  w_valid,
    output logic                       w_ready,
    output axi_wr_pkg::b_resp_t        b,
    output logic                       b_valid,
    input  wire logic                  b_ready,
    // Memory write port
    output axi_wr_pkg::mem_wr_t        mem,
    output logic                       mem_we,
    input  wire logic                  mem_ready
);

    axi_wr_pkg::aw_cmd_t           aw_head;
    axi_wr_pkg::w_beat_t           w_head;
    logic                          aw_full;
    logic                          aw_empty;
    logic                          aw_pop;
    logic                          w_full;
    logic                          w_empty;
    logic                          w_pop;
    logic                          resp_push;
    logic                          resp_size_err;
    logic [axi_wr_pkg::ID_W-1:0]   resp_id;
    logic                          resp_busy;

    // Ready whenever the buffer has room
    assign aw_ready = !aw_full;
    assign w_ready  = !w_full;

    sync_fifo #(
        .WIDTH ($bits(axi_wr_pkg::aw_cmd_t)),
        .DEPTH (axi_wr_pkg::AW_DEPTH)
    ) u_aw_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (aw_valid && aw_ready),
        .din   (aw),
        .full  (aw_full),
        .pop   (aw_pop),
        .dout  (aw_head),
        .empty (aw_empty)
    );

    sync_fifo #(
        .WIDTH ($bits(axi_wr_pkg::w_beat_t)),
        .DEPTH (axi_wr_pkg::W_DEPTH)
    ) u_w_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (w_valid && w_ready),
        .din   (w),
        .full  (w_full),
        .pop   (w_pop),
        .dout  (w_head),
        .empty (w_empty)
    );

    burst_engine u_burst_engine (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd           (aw_head),
        .cmd_empty     (aw_empty),
        .cmd_pop       (aw_pop),
        .beat          (w_head),
        .beat_empty    (w_empty),
        .beat_pop      (w_pop),
        .mem           (mem),
        .mem_we        (mem_we),
        .mem_ready     (mem_ready),
        .resp_push     (resp_push),
        .resp_size_err (resp_size_err),
        .resp_id       (resp_id),
        .resp_busy     (resp_busy)
    );

    wresp_gen u_wresp_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (resp_push),
        .size_err (resp_size_err),
        .id       (resp_id),
        .busy     (resp_busy),
        .b        (b),
        .b_valid  (b_valid),
        .b_ready  (b_ready)
    );

endmodule

`default_nettype wire

/* wresp_gen.sv */
/*
 * Write response stage: response encoding, one-entry hold register
 * and the B channel FIFO.
 */
`timescale 1ns/1ps
`default_nettype none

module wresp_gen (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      push,
    input  wire logic                      size_err,
    input  wire logic [axi_wr_pkg::ID_W-1:0] id,
    output logic                           busy,
    output axi_wr_pkg::b_resp_t            b,
    output logic                           b_valid,
    input  wire logic                      b_ready
);

    axi_wr_pkg::b_resp_t new_resp;
    axi_wr_pkg::b_resp_t hold_resp;
    axi_wr_pkg::b_resp_t fifo_din;
    logic                hold_valid;
    logic                fifo_push;
    logic                fifo_full;
    logic                fifo_empty;

    always_comb begin
        new_resp.id   = id;
        new_resp.resp = size_err ? axi_wr_pkg::SLVERR : axi_wr_pkg::OKAY;
    end

    // Held entry drains first so order is kept
    assign fifo_din  = hold_valid ? hold_resp : new_resp;
    assign fifo_push = !fifo_full && (hold_valid || push);
    assign busy      = hold_valid;
    assign b_valid   = !fifo_empty;

    // ----------------------------------------
    // Hold register
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
        end else if (hold_valid) begin
            if (!fifo_full) hold_valid <= 1'b0;
        end else if (push && fifo_full) begin
            hold_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push && fifo_full && !hold_valid) hold_resp <= new_resp;
    end

    sync_fifo #(
        .WIDTH ($bits(axi_wr_pkg::b_resp_t)),
        .DEPTH (axi_wr_pkg::B_DEPTH)
    ) u_b_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (fifo_push),
        .din   (fifo_din),
        .full  (fifo_full),
        .pop   (b_valid && b_ready),
        .dout  (b),
        .empty (fifo_empty)
    );

endmodule

`default_nettype wire

/* burst_engine.sv */
/*
 * Write burst engine: FSM, beat counter and 4 KB guarded address
 * generator feeding the memory write port.
 */
`timescale 1ns/1ps
`default_nettype none

module burst_engine (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire axi_wr_pkg::aw_cmd_t       cmd,
    input  wire logic                      cmd_empty,
    output logic                           cmd_pop,
    input  wire axi_wr_pkg::w_beat_t       beat,
    input  wire logic                      beat_empty,
    output logic                           beat_pop,
    output axi_wr_pkg::mem_wr_t            mem,
    output logic                           mem_we,
    input  wire logic                      mem_ready,
    output logic                           resp_push,
    output logic                           resp_size_err,
    output logic [axi_wr_pkg::ID_W-1:0]    resp_id,
    input  wire logic                      resp_busy
);

    typedef enum logic [1:0] {
        ST_FIRST,
        ST_BURST,
        ST_RESP
    } state_e;

    state_e                         state;
    logic [axi_wr_pkg::LEN_W-1:0]   cnt;
    // Latched command and decode results
    logic [axi_wr_pkg::ID_W-1:0]    id_q;
    logic [axi_wr_pkg::LEN_W-1:0]   len_q;
    logic [axi_wr_pkg::ADDR_W-1:0]  start_q;
    logic [axi_wr_pkg::ADDR_W-1:0]  incr_q;
    logic                           size_err_q;
    logic [axi_wr_pkg::ADDR_W-1:0]  addr_q;
    // Decode of the FIFO head
    logic [axi_wr_pkg::ADDR_W-1:0]  dec_aligned;
    logic [axi_wr_pkg::ADDR_W-1:0]  dec_incr;
    logic                           dec_size_err;
    // Address path
    logic [axi_wr_pkg::ADDR_W-1:0]  cur_addr;
    logic [axi_wr_pkg::ADDR_W-1:0]  page_ref;
    logic [axi_wr_pkg::ADDR_W-1:0]  sum_addr;
    logic [axi_wr_pkg::ADDR_W-1:0]  nxt_addr;
    logic                           first;
    logic                           last_beat;

    aw_decode u_aw_decode (
        .cmd          (cmd),
        .aligned_addr (dec_aligned),
        .incr         (dec_incr),
        .size_err     (dec_size_err)
    );

    assign first = (state == ST_FIRST);

    // ----------------------------------------
    // Beat issue
    // ----------------------------------------
    // First beat also needs a command, later beats only W data
    assign mem_we    = mem_ready && !beat_empty &&
                       ((first && !cmd_empty) || state == ST_BURST);
    assign beat_pop  = mem_we;
    assign cmd_pop   = mem_we && first;
    assign last_beat = first ? (cmd.len == '0) : (cnt == len_q);

    assign resp_push     = mem_we && last_beat;
    assign resp_size_err = first ? dec_size_err : size_err_q;
    assign resp_id       = first ? cmd.id : id_q;

    // Beat 0 uses the raw start address
    assign cur_addr = first ? cmd.addr : addr_q;
    assign page_ref = first ? cmd.addr : start_q;

    always_comb begin
        mem.id   = resp_id;
        mem.addr = cur_addr;
        mem.data = beat.data;
        mem.strb = beat.strb;
        // W last goes through unchecked
        mem.last = beat.last;
    end

    // ----------------------------------------
    // Next address with 4 KB guard
    // ----------------------------------------
    always_comb begin
        sum_addr = (first ? dec_aligned : addr_q) + (first ? dec_incr : incr_q);
        if (sum_addr[axi_wr_pkg::ADDR_W-1:axi_wr_pkg::PAGE_BIT] ==
            page_ref[axi_wr_pkg::ADDR_W-1:axi_wr_pkg::PAGE_BIT]) begin
            nxt_addr = sum_addr;
        end else begin
            // Would leave the page, repeat the previous beat address
            nxt_addr = cur_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_FIRST;
            cnt   <= '0;
        end else begin
            case (state)
                ST_FIRST: if (mem_we) begin
                    cnt   <= axi_wr_pkg::LEN_W'(1);
                    state <= last_beat ? ST_RESP : ST_BURST;
                end
                ST_BURST: if (mem_we) begin
                    cnt   <= cnt + 1'b1;
                    state <= last_beat ? ST_RESP : ST_BURST;
                end
                // Wait until the response has left the hold register
                ST_RESP: if (!resp_busy) state <= ST_FIRST;
                default: state <= ST_FIRST;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_pop) begin
            id_q       <= cmd.id;
            len_q      <= cmd.len;
            start_q    <= cmd.addr;
            incr_q     <= dec_incr;
            size_err_q <= dec_size_err;
        end
        if (mem_we) addr_q <= nxt_addr;
    end

endmodule

`default_nettype wire

/* aw_decode.sv */
/*
 * AW command decode: aligned start address, per-beat increment and
 * transfer size check.
 */
`timescale 1ns/1ps
`default_nettype none

module aw_decode (
    input  wire axi_wr_pkg::aw_cmd_t         cmd,
    output logic [axi_wr_pkg::ADDR_W-1:0]    aligned_addr,
    output logic [axi_wr_pkg::ADDR_W-1:0]    incr,
    output logic                             size_err
);

    logic [axi_wr_pkg::ADDR_W-1:0] align_mask;

    // ----------------------------------------
    // Alignment
    // ----------------------------------------
    // Clear the low size bits of the start address
    always_comb begin
        align_mask   = {axi_wr_pkg::ADDR_W{1'b1}} << cmd.size;
        aligned_addr = cmd.addr & align_mask;
    end

    // ----------------------------------------
    // Increment
    // ----------------------------------------
    // FIXED holds the address, every other type steps by the byte count
    always_comb begin
        if (cmd.burst == axi_wr_pkg::FIXED) begin
            incr = '0;
        end else begin
            incr = axi_wr_pkg::ADDR_W'(1) << cmd.size;
        end
    end

    // Transfer wider than the data bus
    assign size_err = (cmd.size > axi_wr_pkg::SIZE_W'(axi_wr_pkg::MAX_SIZE));

endmodule

`default_nettype wire

/* sync_fifo.sv */
/*
 * Single-clock FIFO with occupancy count and a head-of-queue read port.
 */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             push,
    input  wire logic [WIDTH-1:0] din,
    output logic                  full,
    input  wire logic             pop,
    output logic      [WIDTH-1:0] dout,
    output logic                  empty
);

    // Storage array, payload only
    logic [WIDTH-1:0]           mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       do_push;
    logic                       do_pop;

    // Ignore writes when full and reads when empty
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == DEPTH);
    assign empty = (count == '0);
    // Head entry is visible the cycle after it was written
    assign dout  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    // ----------------------------------------
    // Pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count unchanged
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* axi_wr_pkg.sv */
/*
 * Shared definitions for the AXI4 write slave: bus widths, FIFO depths,
 * burst and response encodings, and the channel payload structs.
 */
`default_nettype none

package axi_wr_pkg;

    // ----------------------------------------
    // Bus widths
    // ----------------------------------------
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int STRB_W   = DATA_W / 8;
    localparam int ID_W     = 4;
    localparam int LEN_W    = 8;
    localparam int SIZE_W   = 3;
    // Widest legal transfer is log2 of the bus byte count
    localparam int MAX_SIZE = 2;
    // Lowest address bit above a 4 KB page
    localparam int PAGE_BIT = 12;

    // ----------------------------------------
    // Buffer depths
    // ----------------------------------------
    localparam int AW_DEPTH = 4;
    localparam int W_DEPTH  = 16;
    localparam int B_DEPTH  = 4;

    // AXI4 AWBURST encoding, WRAP and RSVD run as INCR here
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10,
        RSVD  = 2'b11
    } burst_e;

    // AXI4 BRESP encoding, only the two codes this slave returns
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

    // AW channel payload, 49 bits
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [SIZE_W-1:0] size;
        burst_e            burst;
    } aw_cmd_t;

    // W channel payload, 37 bits
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } w_beat_t;

    // B channel payload, 6 bits
    typedef struct packed {
        logic [ID_W-1:0] id;
        resp_e           resp;
    } b_resp_t;

    // One beat on the memory write port, 73 bits
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } mem_wr_t;

endpackage

`default_nettype wire
